/* run.sh */
#!/bin/sh
# compile and run the pipeline tail testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module tb_pipe_tail -o sim_tb
out=$(./obj_dir/sim_tb) || true
echo "$out"
if echo "$out" | grep -q "Simulation completed successfully"; then
   exit 0
else
   exit 1
fi

/* source/ctrl_lsu.sv */
// ##################
// control stage
// runs loads and stores on the data memory port
// ##################
`timescale 1ns/10ps

module ctrl_lsu
   import isa_pkg::*;
   import pipe_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     flush_i,
   input  ctrl_op_t ctrl_op_i,
   output logic     dmem_req_o,
   output logic     dmem_we_o,
   output word_t    dmem_addr_o,
   output word_t    dmem_wdata_o,
   input  logic     dmem_ack_i,
   input  word_t    dmem_rdata_i,
   input  logic     dmem_err_i,
   output logic     ctrl_done_o,
   output wb_op_t   wb_op_o
);

   typedef enum logic [1:0] {IDLE, REQ, RELEASE} lsu_state_e;

   lsu_state_e state_q;
   logic       is_mem;
   logic       misaligned;
   logic       needs_bus;
   logic       err_q;
   word_t      rdata_q;

   assign is_mem     = ctrl_op_i.valid && ctrl_op_i.cause == EXC_NONE &&
                       (ctrl_op_i.op == OP_LOAD || ctrl_op_i.op == OP_STORE);
   assign misaligned = |ctrl_op_i.result[1:0];
   assign needs_bus  = is_mem && !misaligned;

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= IDLE;
         err_q   <= 1'b0;
      end else begin
         case (state_q)
            IDLE:    if (needs_bus && !flush_i) state_q <= REQ;
            REQ: begin
               if (dmem_ack_i) begin
                  err_q   <= dmem_err_i;
                  state_q <= RELEASE;
               end
            end
            // wait for the memory to drop ack before finishing
            RELEASE: if (!dmem_ack_i) state_q <= IDLE;
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == REQ && dmem_ack_i) rdata_q <= dmem_rdata_i;
   end

   assign dmem_req_o   = (state_q == REQ);
   assign dmem_we_o    = (ctrl_op_i.op == OP_STORE);
   assign dmem_addr_o  = ctrl_op_i.result;
   assign dmem_wdata_o = ctrl_op_i.store_data;

   // misaligned access never reaches the bus and finishes at once
   assign ctrl_done_o = ctrl_op_i.valid &&
                        (!needs_bus || (state_q == RELEASE && !dmem_ack_i));

   always_comb begin
      wb_op_o.rd        = ctrl_op_i.rd;
      wb_op_o.data      = (ctrl_op_i.op == OP_LOAD) ? rdata_q : ctrl_op_i.result;
      wb_op_o.we        = ctrl_op_i.we;
      wb_op_o.flag_upd  = ctrl_op_i.flag_upd;
      wb_op_o.carry_upd = ctrl_op_i.carry_upd;
      wb_op_o.ovf_upd   = 2'b00;
      if (ctrl_op_i.op == OP_ADD || ctrl_op_i.op == OP_SUB)
         wb_op_o.ovf_upd = {ctrl_op_i.overflow, ~ctrl_op_i.overflow};
      wb_op_o.valid     = ctrl_op_i.valid && !flush_i;
      wb_op_o.cause     = ctrl_op_i.cause;
      if (ctrl_op_i.cause == EXC_NONE && is_mem) begin
         if (misaligned) wb_op_o.cause = EXC_DATA_ALIGN;
         else if (err_q) wb_op_o.cause = EXC_DBUS_ERR;
      end
      wb_op_o.pc        = ctrl_op_i.pc;
   end

endmodule

/* source/execute_ctrl_reg.sv */
// ##################
// execute-to-control register
// holds one op for the control stage, handles bubbles and flush
// ##################
`timescale 1ns/10ps

module execute_ctrl_reg
   import isa_pkg::*;
   import pipe_pkg::*;
#(
   parameter word_t RESET_PC         = 32'h0000_0100,
   parameter bit    FEATURE_OVERFLOW = 1'b1
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     padv_i,
   input  logic     padv_ctrl_i,
   input  logic     flush_i,
   input  ctrl_op_t exec_op_i,
   input  logic     exec_valid_i,
   output ctrl_op_t ctrl_op_o
);

   word_t      pc_q;
   op_e        op_q;
   logic       valid_q;
   exc_cause_e cause_q;
   word_t      result_q;
   word_t      sdata_q;
   reg_addr_t  rd_q;
   logic       we_q;
   flag_upd_t  flag_q;
   flag_upd_t  carry_q;
   logic       ovf_q;

   // pc only moves with a real op, a bubble keeps the last one
   always_ff @(posedge clk) begin
      if (rst) pc_q <= RESET_PC;
      else if (padv_i && exec_valid_i) pc_q <= exec_op_i.pc;
   end

   // advance wins over flush so the op entering now is kept
   always_ff @(posedge clk) begin
      if (rst) begin
         op_q    <= OP_NOP;
         valid_q <= 1'b0;
         cause_q <= EXC_NONE;
      end else if (padv_i) begin
         op_q    <= exec_valid_i ? exec_op_i.op : OP_NOP;
         valid_q <= exec_valid_i;
         cause_q <= exec_valid_i ? exec_op_i.cause : EXC_NONE;
      end else if (padv_ctrl_i || flush_i) begin
         // finished op with nothing behind it turns into a nop bubble
         op_q    <= OP_NOP;
         valid_q <= 1'b0;
         cause_q <= EXC_NONE;
      end
   end

   always_ff @(posedge clk) begin
      if (padv_i) begin
         result_q <= exec_op_i.result;
         sdata_q  <= exec_op_i.store_data;
         rd_q     <= exec_op_i.rd;
         we_q     <= exec_op_i.we;
         flag_q   <= exec_op_i.flag_upd;
         carry_q  <= exec_op_i.carry_upd;
         ovf_q    <= FEATURE_OVERFLOW ? exec_op_i.overflow : 1'b0;
      end
   end

   always_comb begin
      ctrl_op_o.op         = op_q;
      ctrl_op_o.pc         = pc_q;
      ctrl_op_o.result     = result_q;
      ctrl_op_o.store_data = sdata_q;
      ctrl_op_o.rd         = rd_q;
      ctrl_op_o.we         = we_q;
      ctrl_op_o.flag_upd   = flag_q;
      ctrl_op_o.carry_upd  = carry_q;
      ctrl_op_o.overflow   = ovf_q;
      ctrl_op_o.valid      = valid_q;
      ctrl_op_o.cause      = cause_q;
   end

endmodule

/* source/execute_stage.sv */
// ##################
// execute stage
// takes issued ops by four-phase handshake, computes results
// ##################
`timescale 1ns/10ps

module execute_stage
   import isa_pkg::*;
   import pipe_pkg::*;
#(
   parameter bit FEATURE_OVERFLOW = 1'b1
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      issue_req_i,
   input  issue_op_t issue_op_i,
   output logic      issue_ack_o,
   input  logic      padv_i,
   input  logic      flush_i,
   output ctrl_op_t  exec_op_o,
   output logic      exec_valid_o
);

   logic       [32:0] sum;
   logic       [32:0] diff;
   logic              add_ovf;
   logic              sub_ovf;
   logic              accept;
   logic              valid_q;
   ctrl_op_t          nxt;
   ctrl_op_t          slot_q;

   assign sum  = {1'b0, issue_op_i.opa} + {1'b0, issue_op_i.opb};
   assign diff = {1'b0, issue_op_i.opa} - {1'b0, issue_op_i.opb};
   // signed overflow from the operand and result sign bits
   assign add_ovf = (issue_op_i.opa[31] == issue_op_i.opb[31]) &&
                    (sum[31] != issue_op_i.opa[31]);
   assign sub_ovf = (issue_op_i.opa[31] != issue_op_i.opb[31]) &&
                    (diff[31] != issue_op_i.opa[31]);

   always_comb begin
      nxt            = '0;
      nxt.op         = issue_op_i.op;
      nxt.pc         = issue_op_i.pc;
      nxt.store_data = issue_op_i.opb;
      nxt.rd         = issue_op_i.rd;
      nxt.we         = issue_op_i.we;
      nxt.valid      = 1'b1;
      nxt.cause      = EXC_NONE;
      case (issue_op_i.op)
         OP_ADD: begin
            nxt.result    = sum[31:0];
            nxt.carry_upd = {sum[32], ~sum[32]};
            nxt.overflow  = FEATURE_OVERFLOW && add_ovf;
         end
         OP_SUB: begin
            // carry holds the borrow
            nxt.result    = diff[31:0];
            nxt.carry_upd = {diff[32], ~diff[32]};
            nxt.overflow  = FEATURE_OVERFLOW && sub_ovf;
         end
         OP_AND:     nxt.result = issue_op_i.opa & issue_op_i.opb;
         OP_OR:      nxt.result = issue_op_i.opa | issue_op_i.opb;
         OP_XOR:     nxt.result = issue_op_i.opa ^ issue_op_i.opb;
         OP_SFEQ:    nxt.flag_upd = (issue_op_i.opa == issue_op_i.opb) ? 2'b10 : 2'b01;
         OP_SFLTU:   nxt.flag_upd = (issue_op_i.opa < issue_op_i.opb) ? 2'b10 : 2'b01;
         OP_LOAD,
         OP_STORE:   nxt.result = issue_op_i.opa + issue_op_i.imm;
         OP_JAL:     nxt.result = issue_op_i.pc + 32'd8;
         OP_JR: begin
            nxt.result = issue_op_i.opb;
            if (|issue_op_i.opb[1:0]) nxt.cause = EXC_JR_ALIGN;
         end
         OP_SYSCALL: nxt.cause = EXC_SYSCALL;
         OP_TRAP:    nxt.cause = EXC_TRAP;
         OP_ILLEGAL: nxt.cause = EXC_ILLEGAL;
         default:    nxt.result = '0;
      endcase
   end

   // slot must be empty or leaving this cycle
   assign accept = issue_req_i && !issue_ack_o && (!valid_q || padv_i);

   always_ff @(posedge clk) begin
      if (rst) begin
         issue_ack_o <= 1'b0;
         valid_q     <= 1'b0;
      end else begin
         if (accept) issue_ack_o <= 1'b1;
         else if (!issue_req_i) issue_ack_o <= 1'b0;
         // an op taken during a flush is acknowledged and dropped
         if (accept) valid_q <= !flush_i;
         else if (padv_i || flush_i) valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) slot_q <= nxt;
   end

   always_comb begin
      exec_op_o       = slot_q;
      exec_op_o.valid = valid_q;
   end

   assign exec_valid_o = valid_q;

endmodule

/* source/isa_pkg.sv */
// ##################
// isa package
// operation codes, exception causes and word types
// ##################

package isa_pkg;

   // machine word for data, addresses and pc
   typedef logic [31:0] word_t;

   // register file index
   typedef logic [4:0] reg_addr_t;

   // set/clear pair where bit 1 sets and bit 0 clears
   typedef logic [1:0] flag_upd_t;

   // decoded operations with anything unknown arriving as OP_ILLEGAL
   typedef enum logic [3:0] {
      OP_NOP,
      OP_ADD,
      OP_SUB,
      OP_AND,
      OP_OR,
      OP_XOR,
      OP_SFEQ,
      OP_SFLTU,
      OP_LOAD,
      OP_STORE,
      OP_JAL,
      OP_JR,
      OP_SYSCALL,
      OP_TRAP,
      OP_ILLEGAL
   } op_e;

   // exception causes where EXC_NONE must stay the zero code
   typedef enum logic [2:0] {
      EXC_NONE,
      EXC_ILLEGAL,
      EXC_SYSCALL,
      EXC_TRAP,
      EXC_JR_ALIGN,
      EXC_DATA_ALIGN,
      EXC_DBUS_ERR
   } exc_cause_e;

endpackage

/* source/pipe_advance.sv */
// ##################
// pipeline advance
// advance strobes and flush from stage status
// ##################
`timescale 1ns/10ps

module pipe_advance (
   input  logic clk,
   input  logic rst,
   input  logic exec_valid_i,
   input  logic ctrl_busy_i,
   input  logic ctrl_done_i,
   input  logic exc_taken_i,
   output logic padv_exec_o,
   output logic padv_ctrl_o,
   output logic flush_o
);

   // control moves on as soon as its op is done
   assign padv_ctrl_o = ctrl_done_i;

   // hold younger ops back while a fault drains, so the flush catches them
   assign padv_exec_o = exec_valid_i && (!ctrl_busy_i || ctrl_done_i) &&
                        !exc_taken_i && !flush_o;

   // flush lines up with the exception report from writeback
   always_ff @(posedge clk) begin
      if (rst) flush_o <= 1'b0;
      else flush_o <= exc_taken_i;
   end

endmodule

/* source/pipe_pkg.sv */
// ##################
// pipeline package
// records passed between stages and over the issue port
// ##################

package pipe_pkg;

   import isa_pkg::*;

   // decoded op with operands already read
   typedef struct packed {
      op_e       op;
      word_t     pc;
      word_t     opa;
      // store data or jump target
      word_t     opb;
      word_t     imm;
      reg_addr_t rd;
      logic      we;
   } issue_op_t;

   // contents of the execute-to-control register
   typedef struct packed {
      op_e        op;
      word_t      pc;
      // alu result, link value or memory address
      word_t      result;
      word_t      store_data;
      reg_addr_t  rd;
      logic       we;
      flag_upd_t  flag_upd;
      flag_upd_t  carry_upd;
      logic       overflow;
      logic       valid;
      exc_cause_e cause;
   } ctrl_op_t;

   // op leaving the control stage towards writeback
   typedef struct packed {
      reg_addr_t  rd;
      word_t      data;
      logic       we;
      flag_upd_t  flag_upd;
      flag_upd_t  carry_upd;
      flag_upd_t  ovf_upd;
      logic       valid;
      exc_cause_e cause;
      word_t      pc;
   } wb_op_t;

endpackage

/* source/pipe_tail_top.sv */
// ##################
// pipeline tail top
// execute, control register, load/store and writeback
// ##################
`timescale 1ns/10ps

module pipe_tail_top
   import isa_pkg::*;
   import pipe_pkg::*;
#(
   parameter word_t RESET_PC         = 32'h0000_0100,
   parameter bit    FEATURE_OVERFLOW = 1'b1
) (
   input  logic       clk,
   input  logic       rst,
   input  logic       issue_req_i,
   input  issue_op_t  issue_op_i,
   output logic       issue_ack_o,
   output logic       dmem_req_o,
   output logic       dmem_we_o,
   output word_t      dmem_addr_o,
   output word_t      dmem_wdata_o,
   input  logic       dmem_ack_i,
   input  word_t      dmem_rdata_i,
   input  logic       dmem_err_i,
   output logic       rf_we_o,
   output reg_addr_t  rf_addr_o,
   output word_t      rf_wdata_o,
   output logic       flag_o,
   output logic       carry_o,
   output logic       overflow_o,
   output logic       exc_valid_o,
   output exc_cause_e exc_cause_o,
   output word_t      exc_pc_o
);

   ctrl_op_t exec_op;
   ctrl_op_t ctrl_op;
   wb_op_t   wb_in;
   logic     exec_valid;
   logic     ctrl_done;
   logic     exc_taken;
   logic     padv_exec;
   logic     padv_ctrl;
   logic     flush;

   execute_stage #(.FEATURE_OVERFLOW(FEATURE_OVERFLOW)) u_exec (
      .clk, .rst, .issue_req_i, .issue_op_i, .issue_ack_o,
      .padv_i(padv_exec), .flush_i(flush),
      .exec_op_o(exec_op), .exec_valid_o(exec_valid)
   );

   execute_ctrl_reg #(.RESET_PC(RESET_PC), .FEATURE_OVERFLOW(FEATURE_OVERFLOW)) u_ctrl_reg (
      .clk, .rst, .padv_i(padv_exec), .padv_ctrl_i(padv_ctrl), .flush_i(flush),
      .exec_op_i(exec_op), .exec_valid_i(exec_valid), .ctrl_op_o(ctrl_op)
   );

   ctrl_lsu u_lsu (
      .clk, .rst, .flush_i(flush), .ctrl_op_i(ctrl_op),
      .dmem_req_o, .dmem_we_o, .dmem_addr_o, .dmem_wdata_o,
      .dmem_ack_i, .dmem_rdata_i, .dmem_err_i,
      .ctrl_done_o(ctrl_done), .wb_op_o(wb_in)
   );

   writeback_stage u_wb (
      .clk, .rst, .wb_op_i(wb_in), .wb_valid_i(ctrl_done),
      .rf_we_o, .rf_addr_o, .rf_wdata_o, .flag_o, .carry_o, .overflow_o,
      .exc_valid_o, .exc_cause_o, .exc_pc_o, .exc_taken_o(exc_taken)
   );

   // control is busy while it holds a valid op
   pipe_advance u_padv (
      .clk, .rst, .exec_valid_i(exec_valid), .ctrl_busy_i(ctrl_op.valid),
      .ctrl_done_i(ctrl_done), .exc_taken_i(exc_taken),
      .padv_exec_o(padv_exec), .padv_ctrl_o(padv_ctrl), .flush_o(flush)
   );

endmodule

/* source/writeback_stage.sv */
// ##################
// writeback stage
// register write port, status flags, exception report
// ##################
`timescale 1ns/10ps

module writeback_stage
   import isa_pkg::*;
   import pipe_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  wb_op_t     wb_op_i,
   input  logic       wb_valid_i,
   output logic       rf_we_o,
   output reg_addr_t  rf_addr_o,
   output word_t      rf_wdata_o,
   output logic       flag_o,
   output logic       carry_o,
   output logic       overflow_o,
   output logic       exc_valid_o,
   output exc_cause_e exc_cause_o,
   output word_t      exc_pc_o,
   output logic       exc_taken_o
);

   logic accept;
   logic has_exc;

   function automatic logic apply_upd(input logic cur, input flag_upd_t upd);
      if (upd[1]) return 1'b1;
      if (upd[0]) return 1'b0;
      return cur;
   endfunction

   assign accept      = wb_valid_i && wb_op_i.valid;
   assign has_exc     = (wb_op_i.cause != EXC_NONE);
   assign exc_taken_o = accept && has_exc;

   always_ff @(posedge clk) begin
      if (rst) begin
         rf_we_o     <= 1'b0;
         exc_valid_o <= 1'b0;
         flag_o      <= 1'b0;
         carry_o     <= 1'b0;
         overflow_o  <= 1'b0;
      end else begin
         // a faulting op never writes or touches the flags
         rf_we_o     <= accept && wb_op_i.we && !has_exc;
         exc_valid_o <= accept && has_exc;
         if (accept && !has_exc) begin
            flag_o     <= apply_upd(flag_o, wb_op_i.flag_upd);
            carry_o    <= apply_upd(carry_o, wb_op_i.carry_upd);
            overflow_o <= apply_upd(overflow_o, wb_op_i.ovf_upd);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         rf_addr_o   <= wb_op_i.rd;
         rf_wdata_o  <= wb_op_i.data;
         exc_cause_o <= wb_op_i.cause;
         exc_pc_o    <= wb_op_i.pc;
      end
   end

endmodule

/* src.f */
source/isa_pkg.sv
source/pipe_pkg.sv
source/execute_stage.sv
source/execute_ctrl_reg.sv
source/ctrl_lsu.sv
source/writeback_stage.sv
source/pipe_advance.sv
source/pipe_tail_top.sv
test/tb_pipe_tail_checker.sv
test/tb_pipe_tail.sv

/* test/tb_pipe_tail.sv */
// ####################
// pipeline tail testbench
// issuer, data memory model and reference model
// ####################
`timescale 1ns/10ps

module tb_pipe_tail
   import isa_pkg::*;
   import pipe_pkg::*;
;

   localparam int    CLK_PERIOD = 100;
   localparam int    NUM_OPS    = 52;
   localparam word_t RESET_PC   = 32'h0000_0100;

   typedef struct packed {
      logic       is_exc;
      reg_addr_t  rd;
      word_t      data;
      exc_cause_e cause;
      word_t      pc;
   } wb_event_t;

   logic       clk;
   logic       rst;
   logic       issue_req_i;
   issue_op_t  issue_op_i;
   logic       issue_ack_o;
   logic       dmem_req_o;
   logic       dmem_we_o;
   word_t      dmem_addr_o;
   word_t      dmem_wdata_o;
   logic       dmem_ack_i;
   word_t      dmem_rdata_i;
   logic       dmem_err_i;
   logic       rf_we_o;
   reg_addr_t  rf_addr_o;
   word_t      rf_wdata_o;
   logic       flag_o;
   logic       carry_o;
   logic       overflow_o;
   logic       exc_valid_o;
   exc_cause_e exc_cause_o;
   word_t      exc_pc_o;

   // reference model state
   wb_event_t  exp_q[$];
   wb_event_t  ev;
   word_t      ref_regs [32];
   word_t      ref_mem [64];
   logic       ref_flag;
   logic       ref_carry;
   logic       ref_ovf;
   word_t      pc_next;

   // memory model state
   word_t      mem [64];
   logic       faulty [64];
   logic [5:0] mem_idx;
   int         delay_cnt;
   int         mem_min_delay;

   logic [31:0] seed;
   int          errors;

   pipe_tail_top #(.RESET_PC(RESET_PC), .FEATURE_OVERFLOW(1'b1)) DUT (
      .clk(clk), .rst(rst),
      .issue_req_i(issue_req_i), .issue_op_i(issue_op_i), .issue_ack_o(issue_ack_o),
      .dmem_req_o(dmem_req_o), .dmem_we_o(dmem_we_o), .dmem_addr_o(dmem_addr_o),
      .dmem_wdata_o(dmem_wdata_o), .dmem_ack_i(dmem_ack_i), .dmem_rdata_i(dmem_rdata_i),
      .dmem_err_i(dmem_err_i),
      .rf_we_o(rf_we_o), .rf_addr_o(rf_addr_o), .rf_wdata_o(rf_wdata_o),
      .flag_o(flag_o), .carry_o(carry_o), .overflow_o(overflow_o),
      .exc_valid_o(exc_valid_o), .exc_cause_o(exc_cause_o), .exc_pc_o(exc_pc_o)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic word_t rand_word();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   task automatic check_word(input string what, input word_t got, input word_t exp);
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_addr(input string what, input reg_addr_t got, input reg_addr_t exp);
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_cause(input string what, input exc_cause_e got,
                              input exc_cause_e exp);
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
      end
   endtask

   // data memory model answers after a random delay and holds ack until req falls
   assign mem_idx = dmem_addr_o[7:2];

   always @(negedge clk) begin
      if (rst) begin
         dmem_ack_i = 1'b0;
         dmem_err_i = 1'b0;
         delay_cnt  = 0;
      end else if (dmem_req_o && !dmem_ack_i) begin
         if (delay_cnt == 0) begin
            delay_cnt    = mem_min_delay + int'(rand_word() & 32'h3);
            dmem_ack_i   = 1'b1;
            dmem_err_i   = faulty[mem_idx];
            dmem_rdata_i = mem[mem_idx];
            if (dmem_we_o && !faulty[mem_idx]) mem[mem_idx] = dmem_wdata_o;
         end else begin
            delay_cnt = delay_cnt - 1;
         end
      end else if (!dmem_req_o && dmem_ack_i) begin
         dmem_ack_i = 1'b0;
         dmem_err_i = 1'b0;
      end
   end

   // every write or exception report must match the oldest expected event
   always @(negedge clk) begin
      if (!rst && (rf_we_o || exc_valid_o)) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("error at %0t: writeback event with nothing expected", $time);
         end else begin
            ev = exp_q.pop_front();
            if (rf_we_o && ev.is_exc) begin
               errors++;
               $display("error at %0t: register write where an exception was due", $time);
            end else if (exc_valid_o && !ev.is_exc) begin
               errors++;
               $display("error at %0t: exception where a register write was due", $time);
            end else if (rf_we_o) begin
               check_addr("rf_addr_o", rf_addr_o, ev.rd);
               check_word("rf_wdata_o", rf_wdata_o, ev.data);
            end else begin
               check_cause("exc_cause_o", exc_cause_o, ev.cause);
               check_word("exc_pc_o", exc_pc_o, ev.pc);
            end
         end
      end
   end

   task automatic expect_write(input reg_addr_t rd, input word_t data);
      exp_q.push_back('{1'b0, rd, data, EXC_NONE, 32'h0});
      ref_regs[rd] = data;
   endtask

   task automatic expect_exc(input exc_cause_e cause, input word_t pc);
      exp_q.push_back('{1'b1, 5'd0, 32'h0, cause, pc});
   endtask

   // four-phase issue of one op
   task automatic issue(input op_e op, input word_t a, input word_t b, input word_t imm,
                        input reg_addr_t rd, input logic we);
      issue_op_t o;
      o.op    = op;
      o.pc    = pc_next;
      o.opa   = a;
      o.opb   = b;
      o.imm   = imm;
      o.rd    = rd;
      o.we    = we;
      pc_next = pc_next + 32'd4;
      @(negedge clk);
      issue_op_i  = o;
      issue_req_i = 1'b1;
      do @(negedge clk); while (!issue_ack_o);
      issue_req_i = 1'b0;
      do @(negedge clk); while (issue_ack_o);
   endtask

   task automatic drain();
      while (exp_q.size() != 0) @(negedge clk);
      repeat (10) @(negedge clk);
      check_flag("flag_o", flag_o, ref_flag);
      check_flag("carry_o", carry_o, ref_carry);
      check_flag("overflow_o", overflow_o, ref_ovf);
   endtask

   task automatic alu_op(input op_e op, input word_t a, input word_t b, input reg_addr_t rd);
      longint sres;
      word_t  res;
      res = 32'h0;
      sres = 0;
      case (op)
         OP_ADD: begin
            res       = a + b;
            sres      = longint'($signed(a)) + longint'($signed(b));
            ref_carry = ({32'h0, a} + {32'h0, b}) > 64'hffff_ffff;
            ref_ovf   = sres > 64'sd2147483647 || sres < -64'sd2147483648;
         end
         OP_SUB: begin
            res       = a - b;
            sres      = longint'($signed(a)) - longint'($signed(b));
            ref_carry = a < b;
            ref_ovf   = sres > 64'sd2147483647 || sres < -64'sd2147483648;
         end
         OP_AND: res = a & b;
         OP_OR:  res = a | b;
         default: res = a ^ b;
      endcase
      expect_write(rd, res);
      issue(op, a, b, 32'h0, rd, 1'b1);
   endtask

   task automatic test_reset();
      check_flag("issue_ack_o", issue_ack_o, 1'b0);
      check_flag("dmem_req_o", dmem_req_o, 1'b0);
      check_flag("rf_we_o", rf_we_o, 1'b0);
      check_flag("exc_valid_o", exc_valid_o, 1'b0);
      check_flag("flag_o", flag_o, 1'b0);
      check_flag("carry_o", carry_o, 1'b0);
      check_flag("overflow_o", overflow_o, 1'b0);
      check_word("control pc", DUT.ctrl_op.pc, RESET_PC);
   endtask

   task automatic test_alu();
      op_e ops [5];
      ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
      for (int i = 0; i < 10; i++) begin
         alu_op(ops[i % 5], rand_word(), rand_word(), reg_addr_t'(i + 1));
         drain();
      end
      // unsigned wrap and signed overflow corners
      alu_op(OP_ADD, 32'hffff_ffff, 32'h0000_0001, 5'd11);
      drain();
      alu_op(OP_ADD, 32'h7fff_ffff, 32'h0000_0001, 5'd12);
      drain();
   endtask

   task automatic compare(input op_e op, input word_t a, input word_t b);
      if (op == OP_SFEQ) ref_flag = (a == b);
      else ref_flag = (a < b);
      issue(op, a, b, 32'h0, 5'd0, 1'b0);
      // marker write so the drain knows the compare has retired
      alu_op(OP_OR, a, 32'h0, 5'd15);
      drain();
   endtask

   task automatic test_compare();
      word_t x;
      x = rand_word();
      compare(OP_SFEQ, x, x);
      compare(OP_SFEQ, x, x ^ 32'h10);
      compare(OP_SFLTU, 32'h0000_0005, 32'h8000_0000);
      compare(OP_SFLTU, 32'hffff_fff0, 32'h0000_0003);
   endtask

   task automatic store(input int idx, input word_t data);
      ref_mem[idx] = data;
      issue(OP_STORE, word_t'(idx * 4) - 32'd16, data, 32'd16, 5'd0, 1'b0);
   endtask

   task automatic load(input int idx, input reg_addr_t rd);
      expect_write(rd, ref_mem[idx]);
      issue(OP_LOAD, word_t'(idx * 4) + 32'd8, 32'h0, 32'hffff_fff8, rd, 1'b1);
   endtask

   task automatic test_mem();
      int idx [6];
      for (int i = 0; i < 6; i++) begin
         idx[i] = int'(rand_word() % 32'd63);
         store(idx[i], rand_word());
      end
      for (int i = 0; i < 6; i++) load(idx[i], reg_addr_t'(i + 2));
      expect_write(5'd31, pc_next + 32'd8);
      issue(OP_JAL, 32'h0, 32'h0, 32'h0, 5'd31, 1'b1);
      drain();
   endtask

   // the op right behind a fault is flushed and must not write
   task automatic fault(input op_e op, input word_t a, input word_t b, input word_t imm,
                        input exc_cause_e cause);
      expect_exc(cause, pc_next);
      issue(op, a, b, imm, 5'd20, 1'b1);
      issue(OP_ADD, 32'h1, 32'h2, 32'h0, 5'd21, 1'b1);
      drain();
   endtask

   task automatic test_exceptions();
      fault(OP_JR, 32'h0, 32'h0000_0102, 32'h0, EXC_JR_ALIGN);
      fault(OP_LOAD, 32'h0000_0040, 32'h0, 32'h2, EXC_DATA_ALIGN);
      fault(OP_LOAD, 32'h0000_00f0, 32'h0, 32'hc, EXC_DBUS_ERR);
      fault(OP_ILLEGAL, 32'h0, 32'h0, 32'h0, EXC_ILLEGAL);
      fault(OP_SYSCALL, 32'h0, 32'h0, 32'h0, EXC_SYSCALL);
      fault(OP_TRAP, 32'h0, 32'h0, 32'h0, EXC_TRAP);
   endtask

   task automatic test_back_to_back();
      mem_min_delay = 5;
      store(7, rand_word());
      alu_op(OP_ADD, rand_word(), rand_word(), 5'd10);
      load(7, 5'd11);
      // operands come from the sum and the loaded word
      alu_op(OP_XOR, ref_regs[10], ref_regs[11], 5'd12);
      store(40, rand_word());
      load(40, 5'd13);
      alu_op(OP_OR, rand_word(), rand_word(), 5'd14);
      drain();
      mem_min_delay = 0;
   endtask

   // watchdog sized from the op count
   initial begin
      #(64'(NUM_OPS) * 200 * CLK_PERIOD);
      $display("timeout: the pipeline stopped making progress");
      $display("Simulation failed");
      $finish;
   end

   initial begin
      seed          = 32'h00b82d32;
      errors        = 0;
      rst           = 1'b1;
      issue_req_i   = 1'b0;
      issue_op_i    = '0;
      dmem_ack_i    = 1'b0;
      dmem_rdata_i  = '0;
      dmem_err_i    = 1'b0;
      delay_cnt     = 0;
      mem_min_delay = 0;
      pc_next       = 32'h0000_1000;
      ref_flag      = 1'b0;
      ref_carry     = 1'b0;
      ref_ovf       = 1'b0;
      for (int i = 0; i < 64; i++) begin
         mem[i]     = 32'h5a00_0000 | word_t'(i * 4);
         ref_mem[i] = mem[i];
         faulty[i]  = (i == 63);
      end
      for (int i = 0; i < 32; i++) ref_regs[i] = '0;
      repeat (4) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      test_reset();
      test_alu();
      test_compare();
      test_mem();
      test_exceptions();
      test_back_to_back();
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* test/tb_pipe_tail_checker.sv */
// ####################
// protocol checker bound to the pipeline top
// ####################
`timescale 1ns/10ps

module tb_pipe_tail_checker (
   input logic clk,
   input logic rst,
   input logic issue_req_i,
   input logic issue_ack_o,
   input logic dmem_req_o,
   input logic dmem_ack_i,
   input logic rf_we_o,
   input logic exc_valid_o
);

   // requests hold until acknowledged
   // issue ack is registered and may already be up when req falls
   issue_req_hold: assert property (@(posedge clk) disable iff (rst)
      issue_req_i && !issue_ack_o |=> issue_req_i || issue_ack_o)
      else $error("issue req dropped before ack");

   dmem_req_hold: assert property (@(posedge clk) disable iff (rst)
      dmem_req_o && !dmem_ack_i |=> dmem_req_o)
      else $error("dmem req dropped before ack");

   // issue ack answers the req seen in the cycle before
   issue_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
      $rose(issue_ack_o) |-> $past(issue_req_i))
      else $error("issue ack rose without req");

   dmem_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
      $rose(dmem_ack_i) |-> dmem_req_o)
      else $error("dmem ack rose without req");

   write_or_exc: assert property (@(posedge clk) disable iff (rst)
      !(rf_we_o && exc_valid_o))
      else $error("register write and exception in the same cycle");

endmodule

bind pipe_tail_top tb_pipe_tail_checker u_checker (.*);
